/* flist.f */
+incdir+hdl
hdl/aer_pkg.sv
hdl/rr_arbiter.sv
hdl/timestamp_counter.sv
hdl/aer_controller.sv
hdl/event_encoder.sv
hdl/wb_event_port.sv
hdl/aer_arbiter_top.sv
test/aer_arbiter_checker.sv
test/aer_arbiter_tb.sv

/* hdl/aer_arbiter_top.sv */
// aer arbiter top: group arbiters, group-level arbiter, controller, encoder, counter, bus port
`timescale 1ns/1ps
`include "aer_params.svh"

module aer_arbiter_top
(
    input  logic                                            clk_i,
    input  logic                                            reset_i,
    input  aer_pkg::pixel_req_t [`AER_ROWS-1:0][`AER_COLS-1:0] req_i,
    output logic [`AER_ROWS*`AER_COLS-1:0]                  gnt_o,
    input  aer_pkg::wb_req_t                                wb_i,
    output aer_pkg::wb_rsp_t                                wb_o
);

    import aer_pkg::*;

    localparam int NPIX  = `AER_ROWS * `AER_COLS;
    localparam int GPIX  = `AER_GRP_DIM * `AER_GRP_DIM;
    localparam int GCOLS = `AER_COLS / `AER_GRP_DIM;
    localparam int NGRP  = (`AER_ROWS / `AER_GRP_DIM) * GCOLS;

    logic [NPIX-1:0]            req_any;
    logic [NGRP-1:0][GPIX-1:0]  grp_req;
    logic [NGRP-1:0]            grp_any;
    logic [NGRP-1:0]            grp_advance;
    arb_index_t [NGRP-1:0]      pix_winner;
    arb_index_t                 grp_winner;
    logic                       top_advance;
    logic                       capture;
    logic                       pop;
    logic                       ts_clear;
    logic                       ev_valid;
    pixel_addr_t                row;
    pixel_addr_t                col;
    pixel_req_t                 pix_req;
    timestamp_t                 timestamp;
    aer_event_t                 ev;

    // --------------------
    // request reduction
    // --------------------
    // flat index row*cols+col, group slice by (row/2,col/2), pixel by (row%2,col%2)
    always_comb
    begin
        for (int r = 0; r < `AER_ROWS; r++)
        begin
            for (int c = 0; c < `AER_COLS; c++)
            begin
                req_any[r*`AER_COLS + c] = |req_i[r][c];
                grp_req[(r / `AER_GRP_DIM) * GCOLS + c / `AER_GRP_DIM]
                       [(r % `AER_GRP_DIM) * `AER_GRP_DIM + c % `AER_GRP_DIM] = |req_i[r][c];
            end
        end
    end

    // polarity bits of the addressed pixel
    assign pix_req = req_i[row][col];

    // --------------------
    // arbiters
    // --------------------
    for (genvar g = 0; g < NGRP; g++)
    begin : g_grp_arb
        rr_arbiter u_grp_arb (
            .clk_i     (clk_i),
            .reset_i   (reset_i),
            .req_i     (grp_req[g]),
            .advance_i (grp_advance[g]),
            .any_o     (grp_any[g]),
            .winner_o  (pix_winner[g])
        );
    end

    // upper level picks among the group any flags
    rr_arbiter u_top_arb (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .req_i     (grp_any),
        .advance_i (top_advance),
        .any_o     (),
        .winner_o  (grp_winner)
    );

    aer_controller u_ctrl (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .req_any_i     (req_any),
        .grp_any_i     (grp_any),
        .grp_winner_i  (grp_winner),
        .pix_winner_i  (pix_winner),
        .pop_i         (pop),
        .grp_advance_o (grp_advance),
        .top_advance_o (top_advance),
        .capture_o     (capture),
        .row_o         (row),
        .col_o         (col),
        .gnt_o         (gnt_o)
    );

    // --------------------
    // event path
    // --------------------
    event_encoder u_enc (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .capture_i   (capture),
        .pop_i       (pop),
        .row_i       (row),
        .col_i       (col),
        .pix_req_i   (pix_req),
        .timestamp_i (timestamp),
        .valid_o     (ev_valid),
        .event_o     (ev)
    );

    timestamp_counter u_ts (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .clear_i     (ts_clear),
        .timestamp_o (timestamp)
    );

    wb_event_port u_wb (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .wb_i       (wb_i),
        .wb_o       (wb_o),
        .valid_i    (ev_valid),
        .event_i    (ev),
        .pop_o      (pop),
        .ts_clear_o (ts_clear)
    );

endmodule

/* hdl/aer_controller.sv */
// arbitration fsm: request register, grant pulse, arbiter advance, hold until pop
`timescale 1ns/1ps
`include "aer_params.svh"

module aer_controller
(
    input  logic                                  clk_i,
    input  logic                                  reset_i,
    input  logic [`AER_ROWS*`AER_COLS-1:0]        req_any_i,
    input  logic [3:0]                            grp_any_i,
    input  aer_pkg::arb_index_t                   grp_winner_i,
    input  aer_pkg::arb_index_t [3:0]             pix_winner_i,
    input  logic                                  pop_i,
    output logic [3:0]                            grp_advance_o,
    output logic                                  top_advance_o,
    output logic                                  capture_o,
    output aer_pkg::pixel_addr_t                  row_o,
    output aer_pkg::pixel_addr_t                  col_o,
    output logic [`AER_ROWS*`AER_COLS-1:0]        gnt_o
);

    import aer_pkg::*;

    localparam int NPIX = `AER_ROWS * `AER_COLS;

    arb_state_t       state_q;
    arb_state_t       state_d;
    logic [NPIX-1:0]  req_q;
    logic             win_ok;
    logic             capture;
    arb_index_t       pix_win;
    logic [3:0]       pix_sel;

    // --------------------
    // request register
    // --------------------
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            req_q <= '0;
        end
        else
        begin
            req_q <= req_any_i;
        end
    end

    // --------------------
    // winner address
    // --------------------
    // pixel winner of the group that won the upper level
    assign pix_win = pix_winner_i[grp_winner_i];
    // request may have been withdrawn since it was registered
    assign win_ok  = grp_any_i[grp_winner_i];

    // group bit on top, pixel-in-group bit below
    assign row_o   = {grp_winner_i[1], pix_win[1]};
    assign col_o   = {grp_winner_i[0], pix_win[0]};
    assign pix_sel = {row_o, col_o};

    assign capture = (state_q == ARB_GRANT) && win_ok;

    // one-hot grant, only in the grant cycle
    always_comb
    begin
        gnt_o = '0;
        if (capture)
        begin
            gnt_o[pix_sel] = 1'b1;
        end
    end

    // advance the group that won plus the upper level
    always_comb
    begin
        grp_advance_o = '0;
        if (capture)
        begin
            grp_advance_o[grp_winner_i] = 1'b1;
        end
    end

    assign top_advance_o = capture;
    assign capture_o     = capture;

    // --------------------
    // fsm
    // --------------------
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            ARB_IDLE:
            begin
                if (|req_q)
                begin
                    state_d = ARB_GRANT;
                end
            end
            ARB_GRANT:
            begin
                // nothing left to grant, back to idle
                state_d = win_ok ? ARB_HOLD : ARB_IDLE;
            end
            ARB_HOLD:
            begin
                // back-pressure, event still unread
                if (pop_i)
                begin
                    state_d = ARB_SETTLE;
                end
            end
            default:
            begin
                // one cycle to flush stale registered requests
                state_d = ARB_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            state_q <= ARB_IDLE;
        end
        else
        begin
            state_q <= state_d;
        end
    end

endmodule

/* hdl/aer_params.svh */
// array geometry, group size, timestamp and wishbone width macros
`ifndef AER_PARAMS_SVH
`define AER_PARAMS_SVH

// --------------------
// pixel array
// --------------------
// rows and columns of the sensor
`define AER_ROWS 4
`define AER_COLS 4
// edge of one arbitration group
`define AER_GRP_DIM 2

// --------------------
// timestamp
// --------------------
`define AER_TS_WIDTH 16
// clocks per timestamp tick
`define AER_TS_DIV 4

// --------------------
// wishbone slave
// --------------------
`define AER_WB_AW 2
`define AER_WB_DW 32

`endif

/* hdl/aer_pkg.sv */
// shared types for the aer arbiter: addresses, timestamp, event, wishbone, fsm state
`include "aer_params.svh"

package aer_pkg;

    // --------------------
    // pixel side
    // --------------------
    // row or column address
    // msb picks the group, lsb the pixel inside it
    typedef logic [$clog2(`AER_ROWS)-1:0] pixel_addr_t;

    typedef logic [`AER_TS_WIDTH-1:0] timestamp_t;

    // 1 = on, 0 = off
    typedef logic polarity_t;

    // bit 0 on request, bit 1 off request
    typedef logic [1:0] pixel_req_t;

    // winner out of a set of four
    typedef logic [1:0] arb_index_t;

    // event word, 21 bits, sits at the bottom of the read word
    typedef struct packed {
        timestamp_t  timestamp;
        pixel_addr_t row;
        pixel_addr_t col;
        polarity_t   polarity;
    } aer_event_t;

    // controller fsm
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_GRANT,
        ARB_HOLD,
        ARB_SETTLE
    } arb_state_t;

    // --------------------
    // wishbone classic
    // --------------------
    typedef logic [`AER_WB_AW-1:0] wb_addr_t;
    typedef logic [`AER_WB_DW-1:0] wb_data_t;

    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t adr;
        wb_data_t dat;
    } wb_req_t;

    typedef struct packed {
        logic     ack;
        wb_data_t dat;
    } wb_rsp_t;

endpackage

/* hdl/event_encoder.sv */
// polarity selection and the event register with its valid flag
`timescale 1ns/1ps

module event_encoder
(
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 capture_i,
    input  logic                 pop_i,
    input  aer_pkg::pixel_addr_t row_i,
    input  aer_pkg::pixel_addr_t col_i,
    input  aer_pkg::pixel_req_t  pix_req_i,
    input  aer_pkg::timestamp_t  timestamp_i,
    output logic                 valid_o,
    output aer_pkg::aer_event_t  event_o
);

    import aer_pkg::*;

    polarity_t  polarity;
    aer_event_t event_q;
    logic       valid_q;

    // on wins when both bits are set
    assign polarity = pix_req_i[0] ? 1'b1 : 1'b0;

    // --------------------
    // event register
    // --------------------
    always_ff @(posedge clk_i)
    begin
        if (capture_i)
        begin
            event_q.timestamp <= timestamp_i;
            event_q.row       <= row_i;
            event_q.col       <= col_i;
            event_q.polarity  <= polarity;
        end
    end

    // --------------------
    // valid flag
    // --------------------
    // set the cycle after capture, cleared the cycle after pop
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            valid_q <= 1'b0;
        end
        else if (capture_i)
        begin
            valid_q <= 1'b1;
        end
        else if (pop_i)
        begin
            valid_q <= 1'b0;
        end
    end

    assign valid_o = valid_q;
    assign event_o = event_q;

endmodule

/* hdl/rr_arbiter.sv */
// four-way round-robin arbiter with last-winner pointer
`timescale 1ns/1ps
`include "aer_params.svh"

module rr_arbiter
(
    input  logic                                      clk_i,
    input  logic                                      reset_i,
    input  logic [`AER_GRP_DIM*`AER_GRP_DIM-1:0]      req_i,
    input  logic                                      advance_i,
    output logic                                      any_o,
    output aer_pkg::arb_index_t                       winner_o
);

    import aer_pkg::*;

    // same size for the pixel level and the group level
    localparam int N = `AER_GRP_DIM * `AER_GRP_DIM;

    arb_index_t last_q;
    arb_index_t winner;
    logic       found;

    // search starts one past the last winner, wraps around
    always_comb
    begin
        arb_index_t idx;
        winner = last_q;
        found  = 1'b0;
        for (int k = 1; k <= N; k++)
        begin
            idx = last_q + arb_index_t'(k);
            if (!found && req_i[idx])
            begin
                winner = idx;
                found  = 1'b1;
            end
        end
    end

    // pointer reset to 3 so index 0 is looked at first
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            last_q <= arb_index_t'(N - 1);
        end
        else if (advance_i && found)
        begin
            // only moves on its own strobe
            last_q <= winner;
        end
    end

    assign any_o    = found;
    assign winner_o = winner;

endmodule

/* hdl/timestamp_counter.sv */
// prescaled free-running wall clock with synchronous clear
`timescale 1ns/1ps
`include "aer_params.svh"

module timestamp_counter
(
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                clear_i,
    output aer_pkg::timestamp_t timestamp_o
);

    import aer_pkg::*;

    localparam int DIV_W = $clog2(`AER_TS_DIV);
    localparam logic [DIV_W-1:0] PRESC_LAST = DIV_W'(`AER_TS_DIV - 1);

    logic [DIV_W-1:0] presc_q;
    timestamp_t       ts_q;

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            presc_q <= '0;
            ts_q    <= '0;
        end
        else if (clear_i)
        begin
            // host clear, both restart from zero
            presc_q <= '0;
            ts_q    <= '0;
        end
        else if (presc_q == PRESC_LAST)
        begin
            presc_q <= '0;
            // wraps at full width
            ts_q    <= ts_q + 1'b1;
        end
        else
        begin
            presc_q <= presc_q + 1'b1;
        end
    end

    assign timestamp_o = ts_q;

endmodule

/* hdl/wb_event_port.sv */
// wishbone classic slave: status, event pop and timestamp clear registers
`timescale 1ns/1ps

module wb_event_port
(
    input  logic                clk_i,
    input  logic                reset_i,
    input  aer_pkg::wb_req_t    wb_i,
    output aer_pkg::wb_rsp_t    wb_o,
    input  logic                valid_i,
    input  aer_pkg::aer_event_t event_i,
    output logic                pop_o,
    output logic                ts_clear_o
);

    import aer_pkg::*;

    // register map
    localparam wb_addr_t REG_STATUS   = 2'd0;
    localparam wb_addr_t REG_EVENT    = 2'd1;
    localparam wb_addr_t REG_TS_CLEAR = 2'd2;

    logic     access;
    logic     rd_pop;
    logic     wr_clear;
    wb_data_t rd_data;
    logic     ack_q;
    logic     pop_q;
    logic     clear_q;
    wb_data_t dat_q;

    // new access, the ack term keeps it to one per handshake
    assign access   = wb_i.cyc && wb_i.stb && !ack_q;
    assign rd_pop   = access && !wb_i.we && (wb_i.adr == REG_EVENT) && valid_i;
    assign wr_clear = access && wb_i.we && (wb_i.adr == REG_TS_CLEAR);

    // read mux, unmapped addresses read zero
    always_comb
    begin
        rd_data = '0;
        if (wb_i.adr == REG_STATUS)
        begin
            rd_data[0] = valid_i;
        end
        else if ((wb_i.adr == REG_EVENT) && valid_i)
        begin
            rd_data[$bits(aer_event_t)-1:0] = event_i;
        end
    end

    // ack plus side-effect strobes, all one cycle after the request
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            ack_q   <= 1'b0;
            pop_q   <= 1'b0;
            clear_q <= 1'b0;
        end
        else
        begin
            ack_q   <= access;
            pop_q   <= rd_pop;
            clear_q <= wr_clear;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (access)
        begin
            dat_q <= rd_data;
        end
    end

    assign wb_o.ack   = ack_q;
    assign wb_o.dat   = dat_q;
    assign pop_o      = pop_q;
    assign ts_clear_o = clear_q;

endmodule

/* run_sim.sh */
#!/bin/sh
# compile with verilator, run, then decide on the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module aer_arbiter_tb \
    -f flist.f -Mdir obj_dir > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vaer_arbiter_tb > sim.log 2>&1
cat sim.log
grep -q "^Testbench passed$" sim.log \
    && echo "simulation result: pass" \
    || { echo "simulation result: fail"; exit 1; }

/* test/aer_arbiter_checker.sv */
// concurrent assertions on grant pulse, controller state, wishbone ack and event valid
`timescale 1ns/1ps
`include "aer_params.svh"

module aer_arbiter_checker
(
    input logic                               clk_i,
    input logic                               reset_i,
    input logic [`AER_ROWS*`AER_COLS-1:0]     gnt_i,
    input aer_pkg::arb_state_t                state_i,
    input logic                               stb_i,
    input logic                               ack_i,
    input logic                               valid_i,
    input logic                               pop_i
);

    import aer_pkg::*;

    // --------------------
    // controller side
    // --------------------
    // at most one pixel granted per cycle
    gnt_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(gnt_i))
        else $error("grant vector 0x%h has more than one bit set", gnt_i);

    // grant pulse only out of the grant state
    gnt_in_grant: assert property (@(posedge clk_i) disable iff (reset_i)
        (|gnt_i) |-> (state_i == ARB_GRANT))
        else $error("grant 0x%h seen outside the grant state", gnt_i);

    // --------------------
    // bus side
    // --------------------
    ack_needs_stb: assert property (@(posedge clk_i) disable iff (reset_i)
        ack_i |-> stb_i)
        else $error("wishbone ack raised while stb is low");

    // valid clears one cycle after the pop strobe
    valid_drop_on_pop: assert property (@(posedge clk_i) disable iff (reset_i)
        $fell(valid_i) |-> $past(pop_i))
        else $error("event valid fell without a pop");

endmodule

/* test/aer_arbiter_tb.sv */
// testbench for the aer arbiter: stimulus table, round-robin reference model, bus and compare tasks
`timescale 1ns/1ps
`include "aer_params.svh"

module aer_arbiter_tb;

    import aer_pkg::*;

    localparam int NPIX        = `AER_ROWS * `AER_COLS;
    localparam int N_FIXED     = 8;
    localparam int N_RANDOM    = 8;
    localparam int N_ROWS      = N_FIXED + N_RANDOM;
    localparam int GRANT_WAIT  = 8;
    localparam int BUS_WAIT    = 8;
    localparam int POLL_TRIES  = 4;
    localparam int HOLD_CYCLES = 3;
    // worst clocks per event: grant wait, drop, hold, status poll, pop
    localparam int EVENT_CYCLES   = 28;
    // every row at most 16 events, plus the two clear rows and slack
    localparam int TIMEOUT_CYCLES = ((N_ROWS + 2) * NPIX + 4) * EVENT_CYCLES + 200;

    localparam wb_addr_t ADR_STATUS   = 2'd0;
    localparam wb_addr_t ADR_EVENT    = 2'd1;
    localparam wb_addr_t ADR_TS_CLEAR = 2'd2;

    // two request bits per pixel at flat index row*cols+col, and the events expected
    typedef struct packed {
        logic [2*NPIX-1:0] req;
        logic [4:0]        n_events;
    } stim_t;

    logic                                       clk_i;
    logic                                       reset_i;
    pixel_req_t [`AER_ROWS-1:0][`AER_COLS-1:0]  req;
    logic [NPIX-1:0]                            gnt;
    wb_req_t                                    wb_req;
    wb_rsp_t                                    wb_rsp;

    stim_t           stim_table [N_ROWS];
    int              mismatches;
    int              failures;
    int              seed;
    int              cycle_count;
    logic [NPIX-1:0] pending;
    timestamp_t      last_ts;
    logic            clear_pending;
    // reference round-robin pointers
    arb_index_t      ref_top_ptr;
    arb_index_t      ref_grp_ptr [4];

    aer_arbiter_top aer_arbiter_top_i (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .req_i   (req),
        .gnt_o   (gnt),
        .wb_i    (wb_req),
        .wb_o    (wb_rsp)
    );

    // --------------------
    // bound checkers
    // --------------------
    bind aer_controller aer_arbiter_checker u_ctrl_chk (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .gnt_i   (gnt_o),
        .state_i (state_q),
        .stb_i   (1'b0),
        .ack_i   (1'b0),
        .valid_i (1'b0),
        .pop_i   (1'b0)
    );

    bind wb_event_port aer_arbiter_checker u_wb_chk (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .gnt_i   ('0),
        .state_i (aer_pkg::ARB_IDLE),
        .stb_i   (wb_i.stb),
        .ack_i   (wb_o.ack),
        .valid_i (valid_i),
        .pop_i   (pop_o)
    );

    // 40 ns clock
    initial clk_i = 1'b0;
    always #20 clk_i = ~clk_i;

    // run limit
    always @(posedge clk_i)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("errors: mismatches=%0d failures=%0d", mismatches, failures + 1);
            $display("Testbench failed");
            $finish;
        end
    end

    // --------------------
    // compare tasks
    // --------------------
    task automatic check_grant(input logic [NPIX-1:0] act, input logic [NPIX-1:0] exp);
        if (act !== exp)
        begin
            $display("MISMATCH gnt_o expected 0x%h got 0x%h", exp, act);
            mismatches++;
        end
    endtask

    task automatic check_status(input string name, input wb_data_t act, input wb_data_t exp);
        if (act !== exp)
        begin
            $display("MISMATCH %s expected 0x%h got 0x%h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_event(input aer_event_t act, input aer_event_t exp);
        if (act.row !== exp.row)
        begin
            $display("MISMATCH event.row expected 0x%h got 0x%h", exp.row, act.row);
            mismatches++;
        end
        if (act.col !== exp.col)
        begin
            $display("MISMATCH event.col expected 0x%h got 0x%h", exp.col, act.col);
            mismatches++;
        end
        if (act.polarity !== exp.polarity)
        begin
            $display("MISMATCH event.polarity expected 0x%h got 0x%h",
                     exp.polarity, act.polarity);
            mismatches++;
        end
    endtask

    // monotonic between events, lower right after a clear
    task automatic check_timestamp(input timestamp_t act, input timestamp_t prev,
                                   input logic after_clear);
        if (after_clear && !(act < prev))
        begin
            $display("timestamp 0x%h after the clear is not below 0x%h", act, prev);
            failures++;
        end
        else if (!after_clear && (act < prev))
        begin
            $display("timestamp went backwards from 0x%h to 0x%h", prev, act);
            failures++;
        end
    endtask

    // --------------------
    // wishbone master
    // --------------------
    task automatic bus_read(input wb_addr_t adr, output wb_data_t dat);
        int waited;
        waited = 0;
        @(negedge clk_i);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b0;
        wb_req.adr = adr;
        @(negedge clk_i);
        while (!wb_rsp.ack && waited < BUS_WAIT)
        begin
            @(negedge clk_i);
            waited++;
        end
        if (!wb_rsp.ack)
        begin
            $display("bus read of address %0d was never acknowledged", adr);
            failures++;
        end
        dat = wb_rsp.dat;
        // strobe stays up through the rising edge that samples ack
        @(negedge clk_i);
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
    endtask

    task automatic bus_write(input wb_addr_t adr, input wb_data_t dat);
        int waited;
        waited = 0;
        @(negedge clk_i);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b1;
        wb_req.adr = adr;
        wb_req.dat = dat;
        @(negedge clk_i);
        while (!wb_rsp.ack && waited < BUS_WAIT)
        begin
            @(negedge clk_i);
            waited++;
        end
        if (!wb_rsp.ack)
        begin
            $display("bus write to address %0d was never acknowledged", adr);
            failures++;
        end
        // strobe stays up through the rising edge that samples ack
        @(negedge clk_i);
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
    endtask

    // --------------------
    // reference model
    // --------------------
    // group g covers rows 2*(g/2).., cols 2*(g%2)..; position p = (row%2)*2 + col%2
    function automatic int pixel_of(input int grp, input int pos);
        return ((grp / 2) * 2 + pos / 2) * `AER_COLS + (grp % 2) * 2 + pos % 2;
    endfunction

    // next winner from the pending set, pointers move like the hardware
    task automatic predict_next(input logic [NPIX-1:0] pend, output int idx);
        logic [3:0] grp_has;
        int         g;
        int         p;
        grp_has = '0;
        g       = -1;
        p       = -1;
        for (int gi = 0; gi < 4; gi++)
        begin
            for (int pi = 0; pi < 4; pi++)
            begin
                if (pend[pixel_of(gi, pi)])
                begin
                    grp_has[gi] = 1'b1;
                end
            end
        end
        for (int k = 1; k <= 4; k++)
        begin
            if (g < 0 && grp_has[(int'(ref_top_ptr) + k) % 4])
            begin
                g = (int'(ref_top_ptr) + k) % 4;
            end
        end
        idx = -1;
        if (g >= 0)
        begin
            for (int k = 1; k <= 4; k++)
            begin
                if (p < 0 && pend[pixel_of(g, (int'(ref_grp_ptr[g]) + k) % 4)])
                begin
                    p = (int'(ref_grp_ptr[g]) + k) % 4;
                end
            end
            ref_top_ptr    = arb_index_t'(g);
            ref_grp_ptr[g] = arb_index_t'(p);
            idx            = pixel_of(g, p);
        end
    endtask

    // --------------------
    // stimulus
    // --------------------
    task automatic fill_table();
        int cnt;
        stim_table[0] = '{req: 32'h0000_1000, n_events: 5'd1};   // (1,2) on
        stim_table[1] = '{req: 32'h0200_0000, n_events: 5'd1};   // (3,0) off
        stim_table[2] = '{req: 32'h0000_00C0, n_events: 5'd1};   // (0,3) both bits
        stim_table[3] = '{req: 32'h5555_5555, n_events: 5'd16};
        stim_table[4] = '{req: 32'h9B6E_D79E, n_events: 5'd16};
        stim_table[5] = '{req: 32'hFFFF_FFFF, n_events: 5'd16};
        stim_table[6] = '{req: 32'h0101_0101, n_events: 5'd4};
        stim_table[7] = '{req: 32'h8020_0804, n_events: 5'd4};
        for (int i = N_FIXED; i < N_ROWS; i++)
        begin
            stim_table[i].req = $random(seed);
            cnt = 0;
            for (int p = 0; p < NPIX; p++)
            begin
                if (|stim_table[i].req[2*p +: 2])
                begin
                    cnt++;
                end
            end
            stim_table[i].n_events = 5'(cnt);
        end
    endtask

    // apply one row, serve every pixel, check each grant and event
    task automatic run_row(input int row_no, input stim_t stim);
        int              idx;
        int              granted;
        int              waited;
        int              served;
        int              tries;
        wb_data_t        word;
        aer_event_t      ev;
        aer_event_t      exp_ev;
        logic [NPIX-1:0] exp_gnt;
        served = 0;
        @(negedge clk_i);
        pending = '0;
        for (int i = 0; i < NPIX; i++)
        begin
            req[i / `AER_COLS][i % `AER_COLS] = stim.req[2*i +: 2];
            pending[i] = |stim.req[2*i +: 2];
        end
        while (pending != '0)
        begin
            predict_next(pending, idx);
            waited = 0;
            @(negedge clk_i);
            while (gnt == '0 && waited < GRANT_WAIT)
            begin
                @(negedge clk_i);
                waited++;
            end
            if (gnt == '0)
            begin
                $display("row %0d: no grant although %0d pixels still request",
                         row_no, $countones(pending));
                failures++;
                req     = '0;
                pending = '0;
            end
            else
            begin
                exp_gnt      = '0;
                exp_gnt[idx] = 1'b1;
                check_grant(gnt, exp_gnt);
                granted = 0;
                for (int i = 0; i < NPIX; i++)
                begin
                    if (gnt[i])
                    begin
                        granted = i;
                    end
                end
                if (!pending[granted])
                begin
                    $display("row %0d: pixel %0d granted without a request", row_no, granted);
                    failures++;
                end
                // pixel sees its grant, withdraws on the next falling edge
                @(negedge clk_i);
                // grant lasts a single cycle
                check_grant(gnt, '0);
                req[granted / `AER_COLS][granted % `AER_COLS] = '0;
                pending[granted] = 1'b0;
                // event unread, nothing else may be granted
                repeat (HOLD_CYCLES)
                begin
                    @(negedge clk_i);
                    check_grant(gnt, '0);
                end
                tries = 0;
                word  = '0;
                while (!word[0] && tries < POLL_TRIES)
                begin
                    bus_read(ADR_STATUS, word);
                    tries++;
                end
                check_status("status", word, 32'h1);
                // read pops the event
                bus_read(ADR_EVENT, word);
                ev              = word[$bits(aer_event_t)-1:0];
                exp_ev          = '0;
                exp_ev.row      = pixel_addr_t'(idx / `AER_COLS);
                exp_ev.col      = pixel_addr_t'(idx % `AER_COLS);
                exp_ev.polarity = stim.req[2*idx] ? 1'b1 : 1'b0;
                check_event(ev, exp_ev);
                check_timestamp(ev.timestamp, last_ts, clear_pending);
                clear_pending = 1'b0;
                last_ts       = ev.timestamp;
                served++;
            end
        end
        if (served != int'(stim.n_events))
        begin
            $display("row %0d: %0d events served, %0d expected", row_no, served, stim.n_events);
            failures++;
        end
        // no event left, event register reads zero
        bus_read(ADR_STATUS, word);
        check_status("status", word, '0);
        bus_read(ADR_EVENT, word);
        check_status("event word", word, '0);
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial
    begin
        wb_data_t word;
        reset_i       = 1'b1;
        req           = '0;
        wb_req        = '0;
        mismatches    = 0;
        failures      = 0;
        cycle_count   = 0;
        seed          = 64219;
        pending       = '0;
        last_ts       = '0;
        clear_pending = 1'b0;
        ref_top_ptr   = 2'd3;
        for (int g = 0; g < 4; g++)
        begin
            ref_grp_ptr[g] = 2'd3;
        end
        fill_table();

        repeat (10) @(negedge clk_i);
        reset_i = 1'b0;
        check_grant(gnt, '0);
        bus_read(ADR_STATUS, word);
        check_status("status", word, '0);

        for (int i = 0; i < N_FIXED; i++)
        begin
            run_row(i, stim_table[i]);
        end

        // timestamp clear between two single events
        repeat (40) @(negedge clk_i);
        run_row(0, stim_table[0]);
        bus_write(ADR_TS_CLEAR, '0);
        clear_pending = 1'b1;
        run_row(1, stim_table[1]);

        for (int i = N_FIXED; i < N_ROWS; i++)
        begin
            run_row(i, stim_table[i]);
        end

        $display("errors: mismatches=%0d failures=%0d", mismatches, failures);
        if (mismatches == 0 && failures == 0)
        begin
            $display("Testbench passed");
        end
        else
        begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
